// File: all.f
source/rhythm_pkg.sv
source/song_sequencer.sv
source/note_lane.sv
source/score_tally.sv
source/tone_gen.sv
source/rhythm_top.sv
sim/tb_rhythm.sv

// File: sim/tb_rhythm.sv
// testbench for the rhythm core with random songs, key presses, score model and watchdog
module tb_rhythm;
    timeunit 1ns;
    timeprecision 100ps;
    import rhythm_pkg::*;

    localparam int STEPS      = 16;                // steps per song
    localparam int STEP_CLKS  = 40;                // clocks per step
    localparam int HIT_POINTS = 2;
    localparam int EXTRA_COST = 1;
    localparam int NUM_GAMES  = 8;                 // songs, saturation, protection, abort, tone
    localparam int LIMIT_NS   = NUM_GAMES * (STEPS * STEP_CLKS + 200) * 100;

    logic       CLK;
    logic       RESETN;
    logic       menu1;
    logic       menu2;
    logic       back;
    song_sel_t  song_sel;
    logic       song_wr;
    song_addr_t song_addr;
    key_mask_t  song_data;
    key_mask_t  key;
    logic       score_ack;
    game_mode_t mode;
    logic       piezo;
    score_t     score;
    logic       score_req;
    score_t     hit_count;
    score_t     miss_count;

    key_mask_t  song_model [64];                   // copy of the song table
    int         m_score;
    int         m_hit;
    int         m_miss;
    int         err_value;
    int         err_other;

    rhythm_top dut0 (
        .CLK, .RESETN, .menu1, .menu2, .back, .song_sel,
        .song_wr, .song_addr, .song_data, .key, .score_ack,
        .mode, .piezo, .score, .score_req, .hit_count, .miss_count
    );

    always #50 CLK = ~CLK;                         // 100 ns period

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            err_value++;
            $display("FAILED %0t ns %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic tick;
        @(posedge CLK);
        #5;                                        // drive and sample point
    endtask

    function automatic int ones(input key_mask_t v);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            n += v[i];
        end
        return n;
    endfunction

    task automatic write_entry(input int addr, input key_mask_t data);
        song_wr   = 1'b1;
        song_addr = song_addr_t'(addr);
        song_data = data;
        song_model[addr] = data;                   // title mode, so the write lands
        tick;
        song_wr   = 1'b0;
    endtask

    // one full song, model updated per step
    task automatic play_song(input int song, input bit flood, input bit noise);
        key_mask_t note;
        key_mask_t press;
        int        hits;
        int        extras;
        song_sel = song_sel_t'(song);
        menu1    = 1'b1;
        tick;
        menu1    = 1'b0;
        check("mode", MODE_PLAY, mode);
        m_score = 0;
        m_hit   = 0;
        m_miss  = 0;
        for (int s = 0; s < STEPS; s++) begin
            note  = song_model[song * STEPS + s];
            press = '0;
            for (int c = 0; c < STEP_CLKS; c++) begin
                key     = '0;
                song_wr = 1'b0;
                if (c == 20) begin                 // one cycle pulse mid step
                    if (flood)
                        press = key_mask_t'($urandom) | 8'h01;
                    else
                        press = (note & key_mask_t'($urandom))
                              | (key_mask_t'($urandom) & key_mask_t'($urandom)
                                 & key_mask_t'($urandom));
                    key = press;
                end
                if (noise && c == 30) begin        // write attempt, must be dropped
                    song_wr   = 1'b1;
                    song_addr = {song_sel_t'(song), step_t'($urandom)};
                    song_data = key_mask_t'($urandom);
                end
                tick;
            end
            hits    = ones(note & press);
            extras  = ones(~note & press);
            m_hit  += hits;
            m_miss += ones(note & ~press);
            m_score = m_score + HIT_POINTS * hits - EXTRA_COST * extras;
            if (m_score < 0)
                m_score = 0;                       // floor at zero
        end
        key     = '0;
        song_wr = 1'b0;
    endtask

    // report check, delayed ack, blocked restart, then close the handshake
    task automatic finish_handshake;
        int n;
        int delay;
        n = 0;
        while (score_req !== 1'b1 && n < 20) begin
            tick;
            n++;
        end
        if (score_req !== 1'b1) begin
            err_other++;
            $display("score_req did not rise after the last step of the song");
            return;
        end
        check("mode", MODE_REPORT, mode);
        check("score", m_score, score);
        check("hit_count", m_hit, hit_count);
        check("miss_count", m_miss, miss_count);
        delay = $urandom_range(30, 5);
        for (int i = 0; i < delay; i++) begin
            back  = (i == 0);                      // leave report screen
            menu1 = (i == 1);                      // restart try, busy holds it off
            tick;
            check("score_req", 1, score_req);
            check("score", m_score, score);        // frozen while req open
            if (i == 2)
                check("mode", MODE_TITLE, mode);
        end
        back      = 1'b0;
        menu1     = 1'b0;
        score_ack = 1'b1;
        n = 0;
        do begin
            tick;
            n++;
        end while (score_req !== 1'b0 && n < 10);
        if (score_req !== 1'b0) begin
            err_other++;
            $display("score_req stayed high after score_ack was raised");
        end
        repeat ($urandom_range(3, 0)) tick;
        score_ack = 1'b0;
        tick;                                      // busy clears here
    endtask

    // square wave period per lowest held key, silence after release
    task automatic tone_test;
        key_mask_t held;
        int        low;
        int        half;
        int        last;
        int        t;
        int        flips;
        logic      prev;
        repeat (4) begin
            held = key_mask_t'($urandom);
            if (held == '0)
                held = 8'h80;
            low = 0;
            while (!held[low])
                low++;
            half  = 12 - low;                      // 12 down to 5 clocks
            key   = held;
            tick;
            prev  = piezo;
            last  = -1;
            flips = 0;
            t     = 0;
            while (flips < 5 && t < 6 * half + 4) begin
                tick;
                t++;
                if (piezo !== prev) begin
                    if (last >= 0)
                        check("piezo half period", half, t - last);
                    last  = t;
                    flips++;
                    prev  = piezo;
                end
            end
            if (flips < 5) begin
                err_other++;
                $display("piezo did not keep toggling with keys %b held", held);
            end
            key = '0;
            tick;
            repeat (20) begin
                tick;
                check("piezo", 0, piezo);          // parked low
            end
        end
    endtask

    //////////////////////////////
    // watchdog
    //////////////////////////////
    initial begin
        #(LIMIT_NS);
        $display("watchdog expired, the run did not finish in %0d ns", LIMIT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        void'($urandom(32'h4ac9573d));
        CLK       = 1'b0;
        RESETN    = 1'b1;                          // reset active high
        menu1     = 1'b0;
        menu2     = 1'b0;
        back      = 1'b0;
        song_sel  = '0;
        song_wr   = 1'b0;
        song_addr = '0;
        song_data = '0;
        key       = '0;
        score_ack = 1'b0;
        err_value = 0;
        err_other = 0;
        repeat (10) @(posedge CLK);
        #5 RESETN = 1'b0;
        tick;
        check("mode", MODE_TITLE, mode);
        check("score_req", 0, score_req);
        check("piezo", 0, piezo);

        for (int a = 0; a < 64; a++) begin
            write_entry(a, key_mask_t'($urandom));
        end
        write_entry(0, 8'h3c);                     // four notes in song 0, step 0

        song_sel = '0;
        menu1 = 1'b1;                              // start then quit early
        tick;
        menu1 = 1'b0;
        check("mode", MODE_PLAY, mode);
        for (int c = 0; c < STEP_CLKS; c++) begin
            key = (c == 20) ? song_model[0] : '0;  // hit every note of step 0
            tick;
        end
        key = '0;
        tick;                                      // step 0 score lands
        check("score", HIT_POINTS * ones(song_model[0]), score);
        back = 1'b1;
        tick;
        back = 1'b0;
        check("mode", MODE_TITLE, mode);
        check("score", 0, score);
        check("score_req", 0, score_req);
        menu2 = 1'b1;                              // report view, no handshake
        tick;
        menu2 = 1'b0;
        check("mode", MODE_REPORT, mode);
        check("score_req", 0, score_req);
        back = 1'b1;
        tick;
        back = 1'b0;
        check("mode", MODE_TITLE, mode);

        for (int s = 0; s < 4; s++) begin
            play_song(s, 1'b0, 1'b0);
            finish_handshake;
        end

        for (int st = 0; st < STEPS; st++) begin
            write_entry(3 * STEPS + st, '0);       // empty song
        end
        play_song(3, 1'b1, 1'b0);
        finish_handshake;
        check("score", 0, score);

        play_song($urandom_range(3, 0), 1'b0, 1'b1);
        finish_handshake;

        tone_test;

        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value + err_other == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: source/note_lane.sv
// note lane judging one key per step as hit, miss or extra press
module note_lane (
    input  logic CLK,
    input  logic RESETN,
    input  logic key_in,
    input  logic expected,
    input  logic step_end,
    input  logic play,
    output logic hit,
    output logic miss,
    output logic extra,
    output logic verdict_valid
);

    logic key_d;                                   // key one cycle back
    logic rise;                                    // press edge
    logic pressed_q;                               // edge seen this step
    logic press_now;                               // includes a press on step_end

    assign rise      = key_in && !key_d;
    assign press_now = pressed_q || rise;

    always_ff @(posedge CLK or posedge RESETN) begin
        if (RESETN) begin
            key_d <= 1'b0;
        end else begin
            key_d <= key_in;
        end
    end

    // step memory, cleared at each step boundary and outside play
    always_ff @(posedge CLK or posedge RESETN) begin
        if (RESETN) begin
            pressed_q <= 1'b0;
        end else if (step_end || !play) begin
            pressed_q <= 1'b0;
        end else if (rise) begin
            pressed_q <= 1'b1;
        end
    end

    //////////////////////////////
    // verdict, one cycle after step_end
    //////////////////////////////
    always_ff @(posedge CLK or posedge RESETN) begin
        if (RESETN) begin
            hit           <= 1'b0;
            miss          <= 1'b0;
            extra         <= 1'b0;
            verdict_valid <= 1'b0;
        end else begin
            verdict_valid <= step_end;                          // single pulse
            hit           <= step_end && expected && press_now;
            miss          <= step_end && expected && !press_now;
            extra         <= step_end && !expected && press_now;
        end
    end

    // verdict bits are exclusive and only follow a step boundary
    a_one_verdict : assert property (@(posedge CLK) disable iff (RESETN)
        (hit || miss || extra) |-> $onehot0({hit, miss, extra}) && $past(step_end));

endmodule

// File: source/rhythm_pkg.sv
// rhythm package shared widths, step timing, score weights, tone table and game modes
package rhythm_pkg;

    ////////////////////////////////
    // keys and songs
    ////////////////////////////////
    localparam int NUM_KEYS       = 8;             // one lane per key
    localparam int NUM_SONGS      = 4;
    localparam int STEPS_PER_SONG = 16;
    localparam int STEP_CYCLES    = 40;            // short steps for quick runs

    typedef logic [NUM_KEYS-1:0] key_mask_t;       // one bit per key
    typedef logic [1:0]          song_sel_t;       // song number
    typedef logic [3:0]          step_t;           // step within a song
    typedef logic [5:0]          song_addr_t;      // {song, step}

    ////////////////////////////////
    // scoring
    ////////////////////////////////
    typedef logic [9:0] score_t;                   // unsigned, floor at zero
    typedef logic [3:0] count_t;                   // verdicts in one step

    localparam score_t SCORE_HIT   = 10'd2;        // reward per hit
    localparam score_t SCORE_EXTRA = 10'd1;        // cost per stray press

    ////////////////////////////////
    // piezo
    ////////////////////////////////
    typedef logic [3:0] tone_cnt_t;

    // half periods in clocks, key 0 is the lowest pitch
    localparam tone_cnt_t TONE_HALF [NUM_KEYS] = '{
        4'd12, 4'd11, 4'd10, 4'd9, 4'd8, 4'd7, 4'd6, 4'd5
    };

    typedef enum logic [1:0] {
        MODE_TITLE  = 2'd0,                        // menu, song table writable
        MODE_PLAY   = 2'd1,                        // song running
        MODE_REPORT = 2'd2                         // score screen
    } game_mode_t;

endpackage

// File: source/rhythm_top.sv
// rhythm game core top joining sequencer, eight lanes, tally and tone generator
module rhythm_top (
    input  logic                   CLK,
    input  logic                   RESETN,
    input  logic                   menu1,
    input  logic                   menu2,
    input  logic                   back,
    input  rhythm_pkg::song_sel_t  song_sel,
    input  logic                   song_wr,
    input  rhythm_pkg::song_addr_t song_addr,
    input  rhythm_pkg::key_mask_t  song_data,
    input  rhythm_pkg::key_mask_t  key,
    input  logic                   score_ack,
    output rhythm_pkg::game_mode_t mode,
    output logic                   piezo,
    output rhythm_pkg::score_t     score,
    output logic                   score_req,
    output rhythm_pkg::score_t     hit_count,
    output rhythm_pkg::score_t     miss_count
);
    import rhythm_pkg::*;

    key_mask_t note_mask;                          // expected keys this step
    key_mask_t lane_hit;
    key_mask_t lane_miss;
    key_mask_t lane_extra;
    key_mask_t lane_valid;                         // all lanes pulse together
    logic      play;
    logic      step_end;
    logic      start;
    logic      song_done;
    logic      abort;
    logic      busy;

    song_sequencer u_seq (
        .CLK, .RESETN, .menu1, .menu2, .back, .song_sel,
        .song_wr, .song_addr, .song_data, .busy,
        .mode, .play, .note_mask, .step_end, .start, .song_done, .abort
    );

    for (genvar i = 0; i < NUM_KEYS; i++) begin : g_lane
        note_lane u_lane (
            .CLK           (CLK),
            .RESETN        (RESETN),
            .key_in        (key[i]),
            .expected      (note_mask[i]),
            .step_end      (step_end),
            .play          (play),
            .hit           (lane_hit[i]),
            .miss          (lane_miss[i]),
            .extra         (lane_extra[i]),
            .verdict_valid (lane_valid[i])
        );
    end

    score_tally u_tally (
        .CLK, .RESETN,
        .hit (lane_hit), .miss (lane_miss), .extra (lane_extra),
        .verdict_valid (&lane_valid),
        .start, .song_done, .abort, .score_ack,
        .score, .hit_count, .miss_count, .score_req, .busy
    );

    tone_gen u_tone (.CLK, .RESETN, .key, .piezo);

endmodule

// File: source/score_tally.sv
// score tally summing lane verdicts and reporting the result over req/ack
module score_tally (
    input  logic                  CLK,
    input  logic                  RESETN,
    input  rhythm_pkg::key_mask_t hit,
    input  rhythm_pkg::key_mask_t miss,
    input  rhythm_pkg::key_mask_t extra,
    input  logic                  verdict_valid,
    input  logic                  start,
    input  logic                  song_done,
    input  logic                  abort,
    input  logic                  score_ack,
    output rhythm_pkg::score_t    score,
    output rhythm_pkg::score_t    hit_count,
    output rhythm_pkg::score_t    miss_count,
    output logic                  score_req,
    output logic                  busy
);
    import rhythm_pkg::*;

    typedef enum logic [1:0] {
        HS_IDLE,                                   // no report pending
        HS_WAIT,                                   // last score settling
        HS_REQ,                                    // req up, wait ack
        HS_DROP                                    // req down, wait ack low
    } hs_state_t;

    hs_state_t              hs_q;
    count_t                 n_hit;
    count_t                 n_miss;
    count_t                 n_extra;
    logic [$bits(score_t):0] gain;                 // one spare bit
    logic [$bits(score_t):0] penalty;
    score_t                 next_score;

    function automatic count_t popcount(input key_mask_t v);
        count_t n;
        n = '0;
        for (int i = 0; i < NUM_KEYS; i++) begin
            n = n + count_t'(v[i]);
        end
        return n;
    endfunction

    assign n_hit      = popcount(hit);
    assign n_miss     = popcount(miss);
    assign n_extra    = popcount(extra);
    assign gain       = {1'b0, score} + SCORE_HIT * n_hit;
    assign penalty    = SCORE_EXTRA * n_extra;
    assign next_score = (gain > penalty) ? score_t'(gain - penalty) : '0;  // floor at 0
    assign score_req  = (hs_q == HS_REQ);
    assign busy       = (hs_q != HS_IDLE);

    //////////////////////////////
    // accumulation
    //////////////////////////////
    always_ff @(posedge CLK or posedge RESETN) begin
        if (RESETN) begin
            score      <= '0;
            hit_count  <= '0;
            miss_count <= '0;
        end else if (start || abort) begin
            score      <= '0;                                   // fresh game or quit
            hit_count  <= '0;
            miss_count <= '0;
        end else if (verdict_valid) begin
            score      <= next_score;
            hit_count  <= hit_count + score_t'(n_hit);
            miss_count <= miss_count + score_t'(n_miss);
        end
    end

    // four phase handshake
    always_ff @(posedge CLK or posedge RESETN) begin
        if (RESETN) begin
            hs_q <= HS_IDLE;
        end else begin
            case (hs_q)
                HS_IDLE: if (song_done && !abort) hs_q <= HS_WAIT;
                HS_WAIT: hs_q <= HS_REQ;                        // let last verdict land
                HS_REQ:  if (score_ack) hs_q <= HS_DROP;
                HS_DROP: if (!score_ack) hs_q <= HS_IDLE;
                default: hs_q <= HS_IDLE;
            endcase
        end
    end

    // req is withdrawn only after the far side answered
    a_req_held : assert property (@(posedge CLK) disable iff (RESETN)
        $fell(score_req) |-> $past(score_ack));

endmodule

// File: source/song_sequencer.sv
// song sequencer with menu FSM, song table memory and step timing for the lanes
module song_sequencer (
    input  logic                   CLK,
    input  logic                   RESETN,
    input  logic                   menu1,
    input  logic                   menu2,
    input  logic                   back,
    input  rhythm_pkg::song_sel_t  song_sel,
    input  logic                   song_wr,
    input  rhythm_pkg::song_addr_t song_addr,
    input  rhythm_pkg::key_mask_t  song_data,
    input  logic                   busy,
    output rhythm_pkg::game_mode_t mode,
    output logic                   play,
    output rhythm_pkg::key_mask_t  note_mask,
    output logic                   step_end,
    output logic                   start,
    output logic                   song_done,
    output logic                   abort
);
    import rhythm_pkg::*;

    logic [$clog2(STEP_CYCLES)-1:0] cyc_q;                       // cycle within step
    step_t                          step_q;                      // current step
    song_sel_t                      sel_q;                       // song latched at start
    key_mask_t                      song_mem [NUM_SONGS*STEPS_PER_SONG];
    logic                           wr_ok;
    logic                           last_step;

    assign play      = (mode == MODE_PLAY);
    assign wr_ok     = song_wr && (mode == MODE_TITLE);          // table locked outside title
    assign start     = (mode == MODE_TITLE) && menu1 && !busy;   // held off by open handshake
    assign abort     = play && back;
    assign step_end  = play && (cyc_q == $bits(cyc_q)'(STEP_CYCLES - 1));
    assign last_step = (step_q == step_t'(STEPS_PER_SONG - 1));
    assign note_mask = song_mem[{sel_q, step_q}];                // async read of current step

    //////////////////////////////
    // menu FSM
    //////////////////////////////
    always_ff @(posedge CLK or posedge RESETN) begin
        if (RESETN) begin
            mode <= MODE_TITLE;
        end else begin
            case (mode)
                MODE_TITLE: begin
                    if (start) begin
                        mode <= MODE_PLAY;                       // step 0 starts here
                    end else if (menu2) begin
                        mode <= MODE_REPORT;                     // view last score
                    end
                end
                MODE_PLAY: begin
                    if (back) begin
                        mode <= MODE_TITLE;
                    end else if (song_done) begin
                        mode <= MODE_REPORT;                     // one cycle after last step
                    end
                end
                MODE_REPORT: begin
                    if (back) begin
                        mode <= MODE_TITLE;
                    end
                end
                default: mode <= MODE_TITLE;
            endcase
        end
    end

    //////////////////////////////
    // step timing
    //////////////////////////////
    always_ff @(posedge CLK or posedge RESETN) begin
        if (RESETN) begin
            cyc_q     <= '0;
            step_q    <= '0;
            sel_q     <= '0;
            song_done <= 1'b0;
        end else begin
            song_done <= step_end && last_step;                 // lines up with verdicts
            if (start) begin
                cyc_q  <= '0;
                step_q <= '0;
                sel_q  <= song_sel;                              // song fixed for the run
            end else if (play) begin
                if (step_end) begin
                    cyc_q  <= '0;
                    step_q <= step_q + step_t'(1);               // wraps after step 15
                end else begin
                    cyc_q <= cyc_q + 1'b1;
                end
            end
        end
    end

    // song table, no reset on the storage
    always_ff @(posedge CLK) begin
        if (wr_ok) begin
            song_mem[song_addr] <= song_data;
        end
    end

    // steps only run while no score handshake is pending
    a_step_in_play : assert property (@(posedge CLK) disable iff (RESETN)
        step_end |-> (mode == MODE_PLAY) && !busy);

    // a write outside title leaves the addressed entry untouched
    a_table_locked : assert property (@(posedge CLK) disable iff (RESETN)
        (song_wr && mode != MODE_TITLE) |=>
            song_mem[$past(song_addr)] === $past(song_mem[song_addr]));

endmodule

// File: source/tone_gen.sv
// tone generator driving a square wave on the piezo for the lowest pressed key
module tone_gen (
    input  logic                  CLK,
    input  logic                  RESETN,
    input  rhythm_pkg::key_mask_t key,
    output logic                  piezo
);
    import rhythm_pkg::*;

    logic [$clog2(NUM_KEYS)-1:0] idx;              // lowest pressed key
    logic [$clog2(NUM_KEYS)-1:0] idx_q;            // key of the running tone
    logic                        any;
    logic                        any_q;
    logic                        restart;
    tone_cnt_t                   cnt_q;

    // priority pick, lowest bit wins
    always_comb begin
        idx = '0;
        for (int i = NUM_KEYS - 1; i >= 0; i--) begin
            if (key[i]) begin
                idx = i[$clog2(NUM_KEYS)-1:0];
            end
        end
    end

    assign any     = |key;
    assign restart = any && (!any_q || (idx != idx_q));    // new tone

    always_ff @(posedge CLK or posedge RESETN) begin
        if (RESETN) begin
            idx_q <= '0;
            any_q <= 1'b0;
            cnt_q <= '0;
            piezo <= 1'b0;
        end else begin
            idx_q <= idx;
            any_q <= any;
            if (!any) begin
                cnt_q <= '0;
                piezo <= 1'b0;                              // silent and parked low
            end else if (restart) begin
                cnt_q <= '0;
            end else if (cnt_q == TONE_HALF[idx] - tone_cnt_t'(1)) begin
                cnt_q <= '0;
                piezo <= ~piezo;                            // half period done
            end else begin
                cnt_q <= cnt_q + tone_cnt_t'(1);
            end
        end
    end

endmodule
